// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // ####################
  // sizes.
  // ####################

  localparam int WIDTH = 16;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 15;
  localparam int BITVROW = 4;
  localparam int NUMADDR = 60;
  localparam int BITADDR = 6;

  // ####################
  // types.
  // ####################

  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [WIDTH-1:0] data_t;

  // valid means the spare row holds the newest word of this bank.
  typedef struct packed {
    logic valid;
    bank_t bank;
  } map_entry_t;

  typedef struct packed {
    logic en;
    addr_t adr;
    data_t din;
  } wr_port_t;

  typedef struct packed {
    bank_t bank;
    row_t row;
  } loc_t;

  typedef struct packed {
    logic en;
    row_t row;
    data_t data;
  } bank_wr_t;

  typedef struct packed {
    logic en;
    row_t row;
    map_entry_t entry;
  } map_wr_t;

  typedef enum logic [1:0] {
    ROUTE_MAIN,
    ROUTE_SPARE,
    ROUTE_NONE
  } route_e;

  // bank is the low part of the address, row the quotient.
  function automatic loc_t split_addr(addr_t adr);
    loc_t loc;
    loc.bank = bank_t'(adr % addr_t'(NUMVBNK));
    loc.row = row_t'(adr / addr_t'(NUMVBNK));
    return loc;
  endfunction

endpackage

`default_nettype wire

// ==== design/write_mapper.sv ====
`default_nettype none

module write_mapper (
  input  logic                                   clk,
  input  logic                                   rst,
  input  mem_pkg::wr_port_t [1:0]                wr,
  output mem_pkg::row_t [1:0]                    map_rd_row,
  output mem_pkg::row_t                          spare_rd_row,
  input  mem_pkg::map_entry_t [1:0]              map_rd,
  input  mem_pkg::data_t                         spare_rd,
  output mem_pkg::bank_wr_t [mem_pkg::NUMVBNK-1:0] main_wr,
  output mem_pkg::bank_wr_t                      spare_wr,
  output mem_pkg::map_wr_t                       map_wr
);
  import mem_pkg::*;

  loc_t [1:0] in_loc;
  wr_port_t [1:0] wr_q;
  loc_t [1:0] loc;
  map_entry_t [1:0] m;
  data_t spare_old;
  map_wr_t map_wr_q;
  bank_wr_t spare_wr_q;
  logic [1:0] en;
  logic [1:0] mapped;
  logic same_bank;
  route_e route [2];
  map_wr_t map_upd;
  logic evict;
  bank_t evict_bank;
  logic clr_act;
  row_t clr_row;

  // ####################
  // request stage.
  // ####################

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      in_loc[i] = split_addr(wr[i].adr);
      map_rd_row[i] = in_loc[i].row;
    end
    // eviction source is always the row of port 1.
    spare_rd_row = in_loc[1].row;
  end

  always_ff @(posedge clk) begin
    wr_q <= wr;
    map_wr_q <= map_wr;
    spare_wr_q <= spare_wr;
    if (rst) begin
      wr_q[0].en <= 1'b0;
      wr_q[1].en <= 1'b0;
    end
  end

  // map clear starts at row 0 in reset and runs to the last row.
  always_ff @(posedge clk) begin
    clr_act <= rst || (clr_act && (clr_row != row_t'(NUMVROW - 1)));
    if (clr_act) begin
      clr_row <= clr_row + 1'b1;
    end else begin
      clr_row <= '0;
    end
  end

  // ####################
  // commit stage.
  // ####################

  // the commit written at the read edge is missed by the arrays.
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      loc[i] = split_addr(wr_q[i].adr);
      m[i] = map_rd[i];
      if (map_wr_q.en && (map_wr_q.row == loc[i].row)) begin
        m[i] = map_wr_q.entry;
      end
    end
    spare_old = spare_rd;
    if (spare_wr_q.en && (spare_wr_q.row == loc[1].row)) begin
      spare_old = spare_wr_q.data;
    end
  end

  always_comb begin
    // port 1 wins on equal addresses.
    en[0] = wr_q[0].en && !(wr_q[1].en && (wr_q[0].adr == wr_q[1].adr));
    en[1] = wr_q[1].en;
    for (int i = 0; i < 2; i++) begin
      mapped[i] = en[i] && m[i].valid && (m[i].bank == loc[i].bank);
    end
    same_bank = en[0] && en[1] && (loc[0].bank == loc[1].bank);
    route[0] = ROUTE_NONE;
    route[1] = ROUTE_NONE;
    map_upd = '0;
    map_upd.row = loc[1].row;
    evict = 1'b0;
    evict_bank = m[1].bank;
    if (!same_bank) begin
      for (int i = 0; i < 2; i++) begin
        if (en[i]) begin
          route[i] = mapped[i] ? ROUTE_SPARE : ROUTE_MAIN;
        end
      end
      if (mapped[0] && mapped[1]) begin
        route[1] = ROUTE_MAIN;
        map_upd.en = 1'b1;
      end
    end else if (mapped[0]) begin
      route[0] = ROUTE_SPARE;
      route[1] = ROUTE_MAIN;
      map_upd.en = mapped[1];
    end else begin
      route[0] = ROUTE_MAIN;
      route[1] = ROUTE_SPARE;
      if (!mapped[1]) begin
        map_upd.en = 1'b1;
        map_upd.entry.valid = 1'b1;
        map_upd.entry.bank = loc[1].bank;
        // another bank owns the spare row, move it home first.
        evict = m[1].valid;
      end
    end
  end

  always_comb begin
    main_wr = '0;
    spare_wr = '0;
    map_wr = map_upd;
    for (int i = 0; i < 2; i++) begin
      if (route[i] == ROUTE_MAIN) begin
        main_wr[loc[i].bank] = '{en: 1'b1, row: loc[i].row, data: wr_q[i].din};
      end
      if (route[i] == ROUTE_SPARE) begin
        spare_wr = '{en: 1'b1, row: loc[i].row, data: wr_q[i].din};
      end
    end
    if (evict) begin
      main_wr[evict_bank] = '{en: 1'b1, row: loc[1].row, data: spare_old};
    end
    if (clr_act) begin
      map_wr.en = 1'b1;
      map_wr.row = clr_row;
      map_wr.entry = '0;
    end
  end

  a_wr0_range: assert property (@(posedge clk) disable iff (rst)
    wr[0].en |-> (wr[0].adr < addr_t'(NUMADDR)));
  a_wr1_range: assert property (@(posedge clk) disable iff (rst)
    wr[1].en |-> (wr[1].adr < addr_t'(NUMADDR)));
  a_one_spare: assert property (@(posedge clk) disable iff (rst)
    !((route[0] == ROUTE_SPARE) && (route[1] == ROUTE_SPARE)));
  a_evict_bank: assert property (@(posedge clk) disable iff (rst)
    (evict && en[0]) |-> (evict_bank != loc[0].bank));

endmodule

`default_nettype wire

// ==== design/bank_store.sv ====
`default_nettype none

module bank_store (
  input  logic                                   clk,
  input  mem_pkg::loc_t                          rd_loc,
  input  mem_pkg::row_t [1:0]                    map_rd_row,
  input  mem_pkg::row_t                          spare_rd_row,
  input  mem_pkg::bank_wr_t [mem_pkg::NUMVBNK-1:0] main_wr,
  input  mem_pkg::bank_wr_t                      spare_wr,
  input  mem_pkg::map_wr_t                       map_wr,
  output mem_pkg::data_t                         main_q,
  output mem_pkg::data_t                         spare_q,
  output mem_pkg::map_entry_t                    map_q,
  output mem_pkg::map_entry_t [1:0]              map_rd,
  output mem_pkg::data_t                         spare_rd
);
  import mem_pkg::*;

  data_t main_mem [NUMVBNK][NUMVROW];
  row_t map_row [3];

  // ####################
  // main banks.
  // ####################

  // one write per bank, read-first.
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUMVBNK; b++) begin
      if (main_wr[b].en) begin
        main_mem[b][main_wr[b].row] <= main_wr[b].data;
      end
    end
    main_q <= main_mem[rd_loc.bank][rd_loc.row];
  end

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_main_chk
    a_main_row: assert property (@(posedge clk)
      main_wr[b].en |-> (main_wr[b].row < row_t'(NUMVROW)));
  end

  // ####################
  // spare and map copies.
  // ####################

  // copy 0 serves the read port, copy 1 the eviction.
  for (genvar c = 0; c < 2; c++) begin : g_spare
    data_t mem [NUMVROW];
    row_t rd_row;
    data_t q;
    assign rd_row = (c == 0) ? rd_loc.row : spare_rd_row;
    always_ff @(posedge clk) begin
      if (spare_wr.en) begin
        mem[spare_wr.row] <= spare_wr.data;
      end
      q <= mem[rd_row];
    end
  end

  assign spare_q = g_spare[0].q;
  assign spare_rd = g_spare[1].q;

  assign map_row[0] = rd_loc.row;
  assign map_row[1] = map_rd_row[0];
  assign map_row[2] = map_rd_row[1];

  for (genvar c = 0; c < 3; c++) begin : g_map
    map_entry_t mem [NUMVROW];
    map_entry_t q;
    always_ff @(posedge clk) begin
      if (map_wr.en) begin
        mem[map_wr.row] <= map_wr.entry;
      end
      q <= mem[map_row[c]];
    end
  end

  assign map_q = g_map[0].q;
  assign map_rd[0] = g_map[1].q;
  assign map_rd[1] = g_map[2].q;

  a_spare_row: assert property (@(posedge clk)
    spare_wr.en |-> (spare_wr.row < row_t'(NUMVROW)));
  a_map_row: assert property (@(posedge clk)
    map_wr.en |-> (map_wr.row < row_t'(NUMVROW)));

endmodule

`default_nettype wire

// ==== design/read_merge.sv ====
`default_nettype none

module read_merge (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_en,
  input  mem_pkg::loc_t       rd_loc,
  input  mem_pkg::data_t      main_q,
  input  mem_pkg::data_t      spare_q,
  input  mem_pkg::map_entry_t map_q,
  output logic                rd_vld,
  output mem_pkg::data_t      rd_dout
);
  import mem_pkg::*;

  bank_t bank_q;
  logic use_spare;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_en;
    end
  end

  // lines up with the registered array reads.
  always_ff @(posedge clk) begin
    bank_q <= rd_loc.bank;
  end

  // spare holds the newest word when the map names this bank.
  assign use_spare = map_q.valid && (map_q.bank == bank_q);
  assign rd_dout = use_spare ? spare_q : main_q;

  a_rd_range: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> ((int'(rd_loc.row) * NUMVBNK + int'(rd_loc.bank)) < NUMADDR));

endmodule

`default_nettype wire

// ==== design/mem_2w1r.sv ====
`default_nettype none

module mem_2w1r (
  input  logic                    clk,
  input  logic                    rst,
  input  mem_pkg::wr_port_t [1:0] wr,
  input  logic                    rd_en,
  input  mem_pkg::addr_t          rd_adr,
  output logic                    rd_vld,
  output mem_pkg::data_t          rd_dout
);
  import mem_pkg::*;

  loc_t rd_loc;
  row_t [1:0] map_rd_row;
  row_t spare_rd_row;
  map_entry_t [1:0] map_rd;
  data_t spare_rd;
  bank_wr_t [NUMVBNK-1:0] main_wr;
  bank_wr_t spare_wr;
  map_wr_t map_wr;
  data_t main_q;
  data_t spare_q;
  map_entry_t map_q;

  assign rd_loc = split_addr(rd_adr);

  write_mapper mapper (
    .clk(clk),
    .rst(rst),
    .wr(wr),
    .map_rd_row(map_rd_row),
    .spare_rd_row(spare_rd_row),
    .map_rd(map_rd),
    .spare_rd(spare_rd),
    .main_wr(main_wr),
    .spare_wr(spare_wr),
    .map_wr(map_wr)
  );

  bank_store store (
    .clk(clk),
    .rd_loc(rd_loc),
    .map_rd_row(map_rd_row),
    .spare_rd_row(spare_rd_row),
    .main_wr(main_wr),
    .spare_wr(spare_wr),
    .map_wr(map_wr),
    .main_q(main_q),
    .spare_q(spare_q),
    .map_q(map_q),
    .map_rd(map_rd),
    .spare_rd(spare_rd)
  );

  read_merge merge (
    .clk(clk),
    .rst(rst),
    .rd_en(rd_en),
    .rd_loc(rd_loc),
    .main_q(main_q),
    .spare_q(spare_q),
    .map_q(map_q),
    .rd_vld(rd_vld),
    .rd_dout(rd_dout)
  );

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`default_nettype none

module tb_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  mem_pkg::wr_port_t [1:0] wr,
  input  logic                    rd_en,
  input  mem_pkg::addr_t          rd_adr,
  input  logic                    rd_vld,
  input  mem_pkg::data_t          rd_dout,
  output int                      err_count,
  output int                      read_count,
  output int                      pending
);
  import mem_pkg::*;

  localparam int DEPTH = 16;
  localparam int VLD_TIMEOUT = 4;

  data_t model [NUMADDR];
  logic written [NUMADDR];
  wr_port_t [1:0] wr_d1;
  wr_port_t [1:0] wr_d2;
  data_t exp_data [DEPTH];
  logic exp_known [DEPTH];
  addr_t exp_adr [DEPTH];
  int wptr = 0;
  int rptr = 0;

  assign pending = wptr - rptr;

  // ####################
  // reference model.
  // ####################

  // a write lands two edges after it is sampled, ahead of the read of that edge.
  always @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < NUMADDR; a++) begin
        written[a] = 1'b0;
      end
      wr_d1 = '0;
      wr_d2 = '0;
    end else begin
      // port 1 goes last so it wins on equal addresses.
      for (int p = 0; p < 2; p++) begin
        if (wr_d2[p].en) begin
          model[wr_d2[p].adr] = wr_d2[p].din;
          written[wr_d2[p].adr] = 1'b1;
        end
      end
      if (rd_en) begin
        exp_adr[wptr % DEPTH] = rd_adr;
        exp_data[wptr % DEPTH] = model[rd_adr];
        exp_known[wptr % DEPTH] = written[rd_adr];
        wptr = wptr + 1;
      end
      wr_d2 = wr_d1;
      wr_d1 = wr;
    end
  end

  // ####################
  // read checks.
  // ####################

  task automatic check_read();
    int waited;
    int slot;
    waited = 0;
    slot = rptr % DEPTH;
    if (rd_vld !== 1'b1) begin
      $display("FAILED t=%0t rd_vld got %b expected 1", $time, rd_vld);
      err_count++;
    end
    while (rd_vld !== 1'b1 && waited < VLD_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rd_vld !== 1'b1) begin
      $display("timeout: no rd_vld within %0d cycles for the read of address %0d",
               VLD_TIMEOUT, exp_adr[slot]);
      err_count++;
    end else if (exp_known[slot]) begin
      read_count++;
      if (rd_dout !== exp_data[slot]) begin
        $display("FAILED t=%0t rd_dout (adr %0d) got %h expected %h",
                 $time, exp_adr[slot], rd_dout, exp_data[slot]);
        err_count++;
      end
    end
    rptr++;
  endtask

  // outputs are registered in the DUT, so the falling edge sees settled values.
  initial begin
    err_count = 0;
    read_count = 0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (pending > 0) begin
        check_read();
      end else if (rd_vld !== 1'b0) begin
        $display("FAILED t=%0t rd_vld got %b expected 0", $time, rd_vld);
        err_count++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top;
  import mem_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_TIMEOUT = 20;
  localparam int NUM_TESTS = 6;

  logic clk = 1'b0;
  logic rst;
  wr_port_t [1:0] wr;
  logic rd_en;
  addr_t rd_adr;
  logic rd_vld;
  data_t rd_dout;
  int err_count;
  int read_count;
  int pending;
  logic [31:0] rng_state;
  logic timed_out;
  logic late;
  int tests_run;
  int errors_before;

  always #4 clk = ~clk;

  mem_2w1r dut0 (.*);

  tb_checker chk0 (.*);

  // ####################
  // stimulus helpers.
  // ####################

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t rand_addr(int limit);
    return addr_t'(next_rand() % limit);
  endfunction

  // bank is the address modulo the bank count.
  function automatic addr_t addr_of(int row, int bank);
    return addr_t'(row * NUMVBNK + bank);
  endfunction

  function automatic wr_port_t make_write(logic en, addr_t adr);
    wr_port_t w;
    w.en = en;
    w.adr = adr;
    w.din = data_t'(next_rand());
    return w;
  endfunction

  task automatic drive(input wr_port_t w0, input wr_port_t w1, input logic re, input addr_t ra);
    @(negedge clk);
    wr[0] = w0;
    wr[1] = w1;
    rd_en = re;
    rd_adr = ra;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) drive('0, '0, 1'b0, '0);
  endtask

  task automatic read_back(input int count);
    for (int a = 0; a < count; a++) begin
      drive('0, '0, 1'b1, addr_t'(a));
    end
  endtask

  task automatic drain_reads(output logic stuck);
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    stuck = (pending != 0);
  endtask

  function automatic string test_name(int t);
    case (t)
      1: return "idle after reset";
      2: return "random traffic";
      3: return "same-bank pairs";
      4: return "equal write addresses";
      5: return "back-to-back rows";
      default: return "rd_vld timing";
    endcase
  endfunction

  // ####################
  // test phases.
  // ####################

  task automatic run_test(input int t);
    wr_port_t w0;
    wr_port_t w1;
    addr_t ra;
    addr_t hist0;
    addr_t hist1;
    logic [31:0] r;
    int bank;
    hist0 = '0;
    hist1 = '0;
    case (t)
      1: drive_idle(8);
      2: repeat (400) begin
        r = next_rand();
        w0 = make_write(r[0] | r[1], rand_addr(NUMADDR));
        w1 = make_write(r[2] | r[3], rand_addr(NUMADDR));
        drive(w0, w1, 1'b1, rand_addr(NUMADDR));
      end
      3: begin
        // three rows only, both ports in one bank, so the spare row gets contested.
        repeat (300) begin
          bank = int'(next_rand() % NUMVBNK);
          w0 = make_write(1'b1, addr_of(int'(next_rand() % 3), bank));
          w1 = make_write(1'b1, addr_of(int'(next_rand() % 3), bank));
          drive(w0, w1, 1'b1, rand_addr(3 * NUMVBNK));
        end
        drive_idle(2);
        read_back(NUMADDR);
      end
      4: repeat (60) begin
        ra = rand_addr(NUMADDR);
        w0 = make_write(1'b1, ra);
        w1 = make_write(1'b1, ra);
        // the read sees a write two cycles after it.
        drive(w0, w1, 1'b1, hist1);
        hist1 = hist0;
        hist0 = ra;
      end
      5: begin
        repeat (200) begin
          w0 = make_write(1'b1, addr_of(int'(next_rand() % 2), int'(next_rand() % NUMVBNK)));
          w1 = make_write(1'b1, addr_of(int'(next_rand() % 2), int'(next_rand() % NUMVBNK)));
          drive(w0, w1, 1'b1, rand_addr(2 * NUMVBNK));
        end
        drive_idle(2);
        read_back(2 * NUMVBNK);
      end
      default: repeat (200) begin
        r = next_rand();
        w0 = make_write(r[0], rand_addr(NUMADDR));
        w1 = make_write(r[1], rand_addr(NUMADDR));
        drive(w0, w1, r[3:2] == 2'b00, rand_addr(NUMADDR));
      end
    endcase
  endtask

  initial begin
    rst = 1'b1;
    wr = '0;
    rd_en = 1'b0;
    rd_adr = '0;
    rng_state = 32'h0ab933d5;
    timed_out = 1'b0;
    late = 1'b0;
    tests_run = 0;
    errors_before = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      if (!timed_out) begin
        errors_before = err_count;
        run_test(t);
        drive_idle(2);
        drain_reads(late);
        if (late) begin
          $display("timeout: %0d reads still wait for rd_vld after test %0d", pending, t);
          timed_out = 1'b1;
        end
        tests_run++;
        $display("test %0d %s: %0d errors", t, test_name(t), err_count - errors_before);
      end
    end
    $display("tests run: %0d, reads checked: %0d, errors: %0d",
             tests_run, read_count, err_count);
    if (!timed_out && err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/mem_pkg.sv
design/write_mapper.sv
design/bank_store.sv
design/read_merge.sv
design/mem_2w1r.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_top --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  echo "testbench reported a failure"
  exit 1
fi
exit 0
